/* mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Jumping here ends execution
`define MIPS_HALT_ADDR 32'h0000_0000

// General purpose register count
`define MIPS_NUM_REGS 32

`endif

/* mips_pkg.sv */
package mips_pkg;

  // Primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTIU   = 6'h0B,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_XORI    = 6'h0E,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_e;

  // SPECIAL function codes, instr[5:0]
  typedef enum logic [5:0] {
    F_SLL  = 6'h00,
    F_SRL  = 6'h02,
    F_JR   = 6'h08,
    F_ADDU = 6'h21,
    F_SUBU = 6'h23,
    F_AND  = 6'h24,
    F_OR   = 6'h25,
    F_XOR  = 6'h26,
    F_SLT  = 6'h2A,
    F_SLTU = 6'h2B
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_e;

  // Write-back source, link is PC+8
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_src_e;

  // Destination register field
  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} reg_dst_e;

  // Redirect kind of the current instruction
  typedef enum logic [2:0] {PC_NONE, PC_BEQ, PC_BNE, PC_JUMP, PC_JR} pc_sel_e;

endpackage

/* ctrl_if.sv */
// Decoded control bundle, one instruction per cycle
interface ctrl_if (
  input logic clk
);
  mips_pkg::alu_op_e  alu_op;
  // Second operand from immediate
  logic               alu_src_imm;
  // Zero extend for logical immediates
  logic               imm_zero_ext;
  logic               reg_write;
  mips_pkg::reg_dst_e reg_dst;
  mips_pkg::wb_src_e  wb_src;
  logic               mem_read;
  logic               mem_write;
  mips_pkg::pc_sel_e  pc_sel;

  // Clock only for the decoder checks
  modport decoder (
    input  clk,
    output alu_op, alu_src_imm, imm_zero_ext, reg_write, reg_dst,
    output wb_src, mem_read, mem_write, pc_sel
  );

  modport consumer (
    input alu_op, alu_src_imm, imm_zero_ext, reg_write, reg_dst,
    input wb_src, mem_read, mem_write, pc_sel
  );

endinterface

/* control_unit.sv */
module control_unit (
  input  logic [31:0] instr,
  ctrl_if.decoder     ctrl
);
  mips_pkg::opcode_e opcode;
  mips_pkg::funct_e  funct;

  assign opcode = mips_pkg::opcode_e'(instr[31:26]);
  assign funct  = mips_pkg::funct_e'(instr[5:0]);

  always_comb
  begin
    // No-op defaults, nothing written
    ctrl.alu_op       = mips_pkg::ALU_ADD;
    ctrl.alu_src_imm  = 1'b0;
    ctrl.imm_zero_ext = 1'b0;
    ctrl.reg_write    = 1'b0;
    ctrl.reg_dst      = mips_pkg::DST_RT;
    ctrl.wb_src       = mips_pkg::WB_ALU;
    ctrl.mem_read     = 1'b0;
    ctrl.mem_write    = 1'b0;
    ctrl.pc_sel       = mips_pkg::PC_NONE;
    case (opcode)
      mips_pkg::OP_SPECIAL:
      begin
        // R-type writes rd
        ctrl.reg_dst   = mips_pkg::DST_RD;
        ctrl.reg_write = 1'b1;
        case (funct)
          mips_pkg::F_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
          mips_pkg::F_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
          mips_pkg::F_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
          mips_pkg::F_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
          mips_pkg::F_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
          mips_pkg::F_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
          mips_pkg::F_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
          mips_pkg::F_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
          mips_pkg::F_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
          mips_pkg::F_JR:
          begin
            ctrl.reg_write = 1'b0;
            ctrl.pc_sel    = mips_pkg::PC_JR;
          end
          // Unknown funct stays a no-op
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      mips_pkg::OP_ADDIU, mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
      mips_pkg::OP_XORI, mips_pkg::OP_LUI:
      begin
        ctrl.alu_src_imm  = 1'b1;
        ctrl.reg_write    = 1'b1;
        // Logical immediates are zero extended, SLTIU still sign extends
        ctrl.imm_zero_ext = opcode inside {mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
                                           mips_pkg::OP_XORI};
        case (opcode)
          mips_pkg::OP_SLTIU: ctrl.alu_op = mips_pkg::ALU_SLTU;
          mips_pkg::OP_ANDI:  ctrl.alu_op = mips_pkg::ALU_AND;
          mips_pkg::OP_ORI:   ctrl.alu_op = mips_pkg::ALU_OR;
          mips_pkg::OP_XORI:  ctrl.alu_op = mips_pkg::ALU_XOR;
          mips_pkg::OP_LUI:   ctrl.alu_op = mips_pkg::ALU_LUI;
          default:            ctrl.alu_op = mips_pkg::ALU_ADD;
        endcase
      end
      mips_pkg::OP_LW:
      begin
        // Address is rs plus signed offset
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.wb_src      = mips_pkg::WB_MEM;
        ctrl.mem_read    = 1'b1;
      end
      mips_pkg::OP_SW:
      begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      mips_pkg::OP_BEQ: ctrl.pc_sel = mips_pkg::PC_BEQ;
      mips_pkg::OP_BNE: ctrl.pc_sel = mips_pkg::PC_BNE;
      mips_pkg::OP_J:   ctrl.pc_sel = mips_pkg::PC_JUMP;
      mips_pkg::OP_JAL:
      begin
        // Link into r31
        ctrl.pc_sel    = mips_pkg::PC_JUMP;
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = mips_pkg::DST_RA;
        ctrl.wb_src    = mips_pkg::WB_LINK;
      end
      default: ;
    endcase
  end

  // One data access per instruction at most
  mem_strobe_excl_a: assert property (@(posedge ctrl.clk) !(ctrl.mem_read && ctrl.mem_write));

endmodule

/* reg_file.sv */
`include "mips_defs.svh"

module reg_file (
  input  logic        clk,
  input  logic        reset,
  input  logic        commit,
  input  logic [31:0] instr,
  ctrl_if.consumer    ctrl,
  input  logic [31:0] alu_result,
  input  logic [31:0] mem_rdata,
  input  logic [31:0] link_addr,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data,
  output logic [31:0] register_v0
);
  logic [31:0] regs [`MIPS_NUM_REGS];
  logic [4:0]  rs_idx;
  logic [4:0]  rt_idx;
  logic [4:0]  rd_idx;
  logic [4:0]  wr_idx;
  logic [31:0] wb_data;

  assign rs_idx = instr[25:21];
  assign rt_idx = instr[20:16];
  assign rd_idx = instr[15:11];

  // Destination select
  always_comb
  begin
    case (ctrl.reg_dst)
      mips_pkg::DST_RD: wr_idx = rd_idx;
      mips_pkg::DST_RA: wr_idx = 5'd31;
      default:          wr_idx = rt_idx;
    endcase
  end

  // Write-back value select
  always_comb
  begin
    case (ctrl.wb_src)
      mips_pkg::WB_MEM:  wb_data = mem_rdata;
      mips_pkg::WB_LINK: wb_data = link_addr;
      default:           wb_data = alu_result;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++)
        regs[i] <= '0;
    end
    // r0 is never written
    else if (commit && ctrl.reg_write && wr_idx != 5'd0)
    begin
      regs[wr_idx] <= wb_data;
    end
  end

  // Async read ports see r0 as zero through the write guard
  assign rs_data     = regs[rs_idx];
  assign rt_data     = regs[rt_idx];
  assign register_v0 = regs[2];

  // Reads of r0 return zero after any sequence of commits
  r0_read_zero_a: assert property (@(posedge clk) disable iff (reset)
    (rs_idx != 5'd0 || rs_data == 32'd0) && (rt_idx != 5'd0 || rt_data == 32'd0));

endmodule

/* alu.sv */
module alu (
  input  logic [31:0] instr,
  ctrl_if.consumer    ctrl,
  input  logic [31:0] rs_data,
  input  logic [31:0] rt_data,
  output logic [31:0] result,
  output logic        zero
);
  logic [15:0] imm;
  logic [4:0]  shamt;
  logic [31:0] imm_ext;
  logic [31:0] op_b;

  assign imm   = instr[15:0];
  assign shamt = instr[10:6];

  // Immediate extension
  assign imm_ext = ctrl.imm_zero_ext ? {16'd0, imm} : {{16{imm[15]}}, imm};

  // Second operand, rt or immediate
  assign op_b = ctrl.alu_src_imm ? imm_ext : rt_data;

  always_comb
  begin
    case (ctrl.alu_op)
      mips_pkg::ALU_ADD:  result = rs_data + op_b;
      mips_pkg::ALU_SUB:  result = rs_data - op_b;
      mips_pkg::ALU_AND:  result = rs_data & op_b;
      mips_pkg::ALU_OR:   result = rs_data | op_b;
      mips_pkg::ALU_XOR:  result = rs_data ^ op_b;
      // Signed compare
      mips_pkg::ALU_SLT:  result = {31'd0, $signed(rs_data) < $signed(op_b)};
      mips_pkg::ALU_SLTU: result = {31'd0, rs_data < op_b};
      // Shifts act on rt by shamt
      mips_pkg::ALU_SLL:  result = rt_data << shamt;
      mips_pkg::ALU_SRL:  result = rt_data >> shamt;
      mips_pkg::ALU_LUI:  result = {imm, 16'd0};
      default:            result = rs_data + op_b;
    endcase
  end

  // Branch compare, rs against rt
  assign zero = (rs_data == rt_data);

endmodule

/* pc_unit.sv */
`include "mips_defs.svh"

module pc_unit (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic [31:0] instr,
  ctrl_if.consumer    ctrl,
  input  logic        zero,
  input  logic [31:0] rs_data,
  output logic [31:0] pc,
  output logic [31:0] link_addr,
  output logic        commit,
  output logic        active
);
  logic [31:0] pc_plus4;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic [31:0] target;
  logic        taken;
  logic [31:0] next_pc;
  // Delay-slot target held for one instruction
  logic        pending_valid;
  logic [31:0] pending_target;

  assign pc_plus4  = pc + 32'd4;
  assign link_addr = pc + 32'd8;

  // Offset relative to the delay slot
  assign branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};

  always_comb
  begin
    taken  = 1'b0;
    target = branch_target;
    case (ctrl.pc_sel)
      mips_pkg::PC_BEQ:  taken = zero;
      mips_pkg::PC_BNE:  taken = !zero;
      mips_pkg::PC_JUMP:
      begin
        taken  = 1'b1;
        target = jump_target;
      end
      mips_pkg::PC_JR:
      begin
        taken  = 1'b1;
        target = rs_data;
      end
      default: ;
    endcase
  end

  // Sequential unless a target is pending
  assign next_pc = pending_valid ? pending_target : pc_plus4;
  assign commit  = clk_enable && active;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc             <= `MIPS_RESET_VECTOR;
      active         <= 1'b1;
      pending_valid  <= 1'b0;
      pending_target <= '0;
    end
    else if (commit)
    begin
      pc             <= next_pc;
      pending_valid  <= taken;
      pending_target <= target;
      // Halt when heading to the halt address
      if (next_pc == `MIPS_HALT_ADDR)
        active <= 1'b0;
    end
  end

  // Misaligned JR target would show up here
  pc_aligned_a: assert property (@(posedge clk) disable iff (reset) active |-> pc[1:0] == 2'b00);

endmodule

/* mips_cpu_harvard.sv */
module mips_cpu_harvard (
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,
  input  logic        clk_enable,
  // Combinational instruction fetch
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  // Combinational read, single-cycle write
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);
  logic        commit;
  logic        zero;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] alu_result;
  logic [31:0] link_addr;

  ctrl_if ctrl_bus (.clk(clk));

  control_unit control_unit_inst (.instr(instr_readdata), .ctrl(ctrl_bus.decoder));

  reg_file reg_file_inst (
    .clk(clk), .reset(reset), .commit(commit), .instr(instr_readdata),
    .ctrl(ctrl_bus.consumer), .alu_result(alu_result), .mem_rdata(data_readdata),
    .link_addr(link_addr), .rs_data(rs_data), .rt_data(rt_data),
    .register_v0(register_v0)
  );

  alu alu_inst (
    .instr(instr_readdata), .ctrl(ctrl_bus.consumer), .rs_data(rs_data),
    .rt_data(rt_data), .result(alu_result), .zero(zero)
  );

  pc_unit pc_unit_inst (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .instr(instr_readdata),
    .ctrl(ctrl_bus.consumer), .zero(zero), .rs_data(rs_data), .pc(instr_address),
    .link_addr(link_addr), .commit(commit), .active(active)
  );

  // Data port straight from ALU and rt
  assign data_address   = alu_result;
  assign data_writedata = rt_data;

  // Strobes quiet in reset and after halt
  assign data_read  = ctrl_bus.mem_read && active && !reset;
  assign data_write = ctrl_bus.mem_write && active && !reset;

endmodule

/* tb_mem_model.sv */
`include "mips_defs.svh"

module tb_mem_model (
  input  logic        clk,
  input  logic [31:0] instr_address,
  output logic [31:0] instr_readdata,
  input  logic [31:0] data_address,
  input  logic        data_write,
  input  logic [31:0] data_writedata,
  output logic [31:0] data_readdata
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROM_WORDS = 64;
  localparam int RAM_WORDS = 256;

  logic [31:0] rom [ROM_WORDS];
  logic [31:0] ram [RAM_WORDS];
  logic [31:0] rom_off;

  // ROM starts at the reset vector
  assign rom_off = instr_address - `MIPS_RESET_VECTOR;
  // Outside the program reads as nop
  assign instr_readdata = (rom_off < ROM_WORDS * 4) ? rom[rom_off[7:2]] : 32'd0;

  // Word-addressed combinational read
  assign data_readdata = ram[data_address[9:2]];

  always @(posedge clk)
  begin
    if (data_write)
      ram[data_address[9:2]] <= data_writedata;
  end

  task clear_rom;
    for (int i = 0; i < ROM_WORDS; i++)
      rom[i] = 32'd0;
  endtask

  // Background is the inverted byte address
  task fill_ram;
    for (int i = 0; i < RAM_WORDS; i++)
      ram[i] = ~(32'(i) << 2);
  endtask

  task load_word(input int idx, input logic [31:0] word);
    rom[idx] = word;
  endtask

  function automatic logic [31:0] peek(input logic [31:0] addr);
    return ram[addr[9:2]];
  endfunction

endmodule

/* tb_mips_cpu_harvard.sv */
`include "mips_defs.svh"

module tb_mips_cpu_harvard;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;
  // Random clk_enable gaps when set
  logic        stall_mode;

  // Program under construction and expected stored results
  logic [31:0] prog [$];
  logic [31:0] exp_ram [$];

  mips_cpu_harvard mips_cpu_harvard_inst (
    .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
    .clk_enable(clk_enable), .instr_address(instr_address),
    .instr_readdata(instr_readdata), .data_address(data_address),
    .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  tb_mem_model mem_inst (
    .clk(clk), .instr_address(instr_address), .instr_readdata(instr_readdata),
    .data_address(data_address), .data_write(data_write),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Enable pattern driven just after each rising edge
  initial
  begin
    forever
    begin
      @(posedge clk);
      #10 clk_enable = stall_mode ? ($urandom % 4 != 0) : 1'b1;
    end
  end

  // Budget covers every test with margin
  initial
  begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("CHECKS FAILED");
    $fatal(1, "Watchdog expired, the core did not halt in time");
  end

  task check_equal(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // Encoders
  function automatic logic [31:0] r_op(input logic [5:0] funct, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] sa);
    return {6'd0, rs, rt, rd, sa, funct};
  endfunction

  function automatic logic [31:0] i_op(input logic [5:0] op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] j_op(input logic [5:0] op, input logic [31:0] target);
    return {op, target[27:2]};
  endfunction

  task emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task load_const(input logic [4:0] rt, input logic [31:0] value);
    emit(i_op(mips_pkg::OP_LUI, rt, 5'd0, value[31:16]));
    emit(i_op(mips_pkg::OP_ORI, rt, rt, value[15:0]));
  endtask

  // Result lands in v0 and is stored to the next RAM word
  task result_op(input logic [31:0] instr, input logic [31:0] expected);
    emit(instr);
    emit(i_op(mips_pkg::OP_SW, 5'd2, 5'd0, 16'(exp_ram.size() * 4)));
    exp_ram.push_back(expected);
  endtask

  // jr $0 plus a nop in its slot
  task emit_halt;
    emit(r_op(mips_pkg::F_JR, 5'd0, 5'd0, 5'd0, 5'd0));
    emit(32'd0);
  endtask

  // Load the ROM, hold reset for 5 cycles and wait for the halt
  task run_program;
    logic        prev_en;
    logic [31:0] prev_pc;
    mem_inst.clear_rom();
    mem_inst.fill_ram();
    for (int i = 0; i < prog.size(); i++)
      mem_inst.load_word(i, prog[i]);
    @(posedge clk);
    #10 reset = 1'b1;
    repeat (5)
    begin
      @(negedge clk);
      check_equal("data_write", data_write, 32'd0);
      check_equal("data_read", data_read, 32'd0);
      @(posedge clk);
    end
    #10 reset = 1'b0;
    prev_en = 1'b1;
    prev_pc = instr_address;
    do
    begin
      @(negedge clk);
      // A disabled edge leaves the PC in place
      if (!prev_en)
        check_equal("instr_address", instr_address, prev_pc);
      prev_en = clk_enable;
      prev_pc = instr_address;
    end
    while (active !== 1'b0);
  endtask

  task check_results;
    for (int i = 0; i < exp_ram.size(); i++)
      check_equal($sformatf("ram[0x%0h]", i * 4), mem_inst.peek(i * 4), exp_ram[i]);
    check_equal("register_v0", register_v0, exp_ram[$]);
  endtask

  task arith_logic_ops;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [15:0] imm;
    logic [4:0]  sa;
    a    = $urandom;
    b    = $urandom;
    imm  = $urandom;
    sa   = $urandom;
    sext = {{16{imm[15]}}, imm};
    prog.delete();
    exp_ram.delete();
    // Store at the reset vector exposes data_write during reset
    emit(i_op(mips_pkg::OP_SW, 5'd0, 5'd0, 16'h03FC));
    load_const(5'd8, a);
    load_const(5'd9, b);
    result_op(r_op(mips_pkg::F_ADDU, 5'd2, 5'd8, 5'd9, 5'd0), a + b);
    result_op(r_op(mips_pkg::F_SUBU, 5'd2, 5'd8, 5'd9, 5'd0), a - b);
    result_op(r_op(mips_pkg::F_AND, 5'd2, 5'd8, 5'd9, 5'd0), a & b);
    result_op(r_op(mips_pkg::F_OR, 5'd2, 5'd8, 5'd9, 5'd0), a | b);
    result_op(r_op(mips_pkg::F_XOR, 5'd2, 5'd8, 5'd9, 5'd0), a ^ b);
    result_op(r_op(mips_pkg::F_SLT, 5'd2, 5'd8, 5'd9, 5'd0),
              ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    result_op(r_op(mips_pkg::F_SLTU, 5'd2, 5'd8, 5'd9, 5'd0), (a < b) ? 32'd1 : 32'd0);
    // Shifts take rt and shamt
    result_op(r_op(mips_pkg::F_SLL, 5'd2, 5'd0, 5'd9, sa), b << sa);
    result_op(r_op(mips_pkg::F_SRL, 5'd2, 5'd0, 5'd9, sa), b >> sa);
    result_op(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd8, imm), a + sext);
    // SLTIU sign extends and then compares unsigned
    result_op(i_op(mips_pkg::OP_SLTIU, 5'd2, 5'd8, imm), (a < sext) ? 32'd1 : 32'd0);
    result_op(i_op(mips_pkg::OP_ANDI, 5'd2, 5'd8, imm), a & {16'd0, imm});
    result_op(i_op(mips_pkg::OP_ORI, 5'd2, 5'd8, imm), a | {16'd0, imm});
    result_op(i_op(mips_pkg::OP_XORI, 5'd2, 5'd8, imm), a ^ {16'd0, imm});
    result_op(i_op(mips_pkg::OP_LUI, 5'd2, 5'd0, imm), {imm, 16'd0});
    emit_halt();
    run_program();
    check_results();
  endtask

  // Rerun of the arithmetic program with enable gaps
  task stalled_rerun;
    stall_mode = 1'b1;
    run_program();
    check_results();
    repeat (8)
    begin
      @(negedge clk);
      check_equal("active", active, 32'd0);
      check_equal("register_v0", register_v0, exp_ram[$]);
    end
    stall_mode = 1'b0;
  endtask

  task load_store_sum;
    logic [31:0] a;
    logic [31:0] b;
    a = $urandom;
    b = $urandom;
    prog.delete();
    // Load at the reset vector exposes data_read during reset
    emit(i_op(mips_pkg::OP_LW, 5'd15, 5'd0, 16'h03FC));
    load_const(5'd8, a);
    load_const(5'd9, b);
    emit(r_op(mips_pkg::F_ADDU, 5'd10, 5'd8, 5'd9, 5'd0));
    // Base pointer in $11
    emit(i_op(mips_pkg::OP_ADDIU, 5'd11, 5'd0, 16'h0040));
    emit(i_op(mips_pkg::OP_SW, 5'd8, 5'd11, 16'd0));
    emit(i_op(mips_pkg::OP_SW, 5'd9, 5'd11, 16'd4));
    emit(i_op(mips_pkg::OP_SW, 5'd10, 5'd11, 16'd8));
    emit(i_op(mips_pkg::OP_LW, 5'd12, 5'd11, 16'd0));
    emit(i_op(mips_pkg::OP_LW, 5'd13, 5'd11, 16'd4));
    emit(i_op(mips_pkg::OP_LW, 5'd14, 5'd11, 16'd8));
    emit(r_op(mips_pkg::F_ADDU, 5'd2, 5'd12, 5'd13, 5'd0));
    emit(r_op(mips_pkg::F_ADDU, 5'd2, 5'd2, 5'd14, 5'd0));
    emit_halt();
    run_program();
    check_equal("ram[0x40]", mem_inst.peek(32'h40), a);
    check_equal("ram[0x44]", mem_inst.peek(32'h44), b);
    check_equal("ram[0x48]", mem_inst.peek(32'h48), a + b);
    check_equal("register_v0", register_v0, (a + b) + (a + b));
  endtask

  // Taken branches skip one word past the slot
  task branch_slots;
    prog.delete();
    emit(i_op(mips_pkg::OP_ADDIU, 5'd8, 5'd0, 16'd5));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd9, 5'd0, 16'd5));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd0, 16'd0));
    emit(i_op(mips_pkg::OP_BEQ, 5'd9, 5'd8, 16'd2));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0100));
    // Untaken BNE runs both following words
    emit(i_op(mips_pkg::OP_BNE, 5'd9, 5'd8, 16'd2));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0002));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0004));
    emit(i_op(mips_pkg::OP_BNE, 5'd0, 5'd8, 16'd2));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0008));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0200));
    // Untaken BEQ against $0 runs both following words
    emit(i_op(mips_pkg::OP_BEQ, 5'd0, 5'd8, 16'd2));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0010));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0020));
    emit_halt();
    run_program();
    // Sum of every slot and fall-through word
    check_equal("register_v0", register_v0, 32'h1 + 32'h2 + 32'h4 + 32'h8 + 32'h10 + 32'h20);
  endtask

  task jal_jr_call;
    prog.delete();
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd0, 16'd7));
    // Call to word 6
    emit(j_op(mips_pkg::OP_JAL, `MIPS_RESET_VECTOR + 32'd24));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd1));
    emit(i_op(mips_pkg::OP_SW, 5'd31, 5'd0, 16'h0080));
    emit_halt();
    // Subroutine
    emit(r_op(mips_pkg::F_SLL, 5'd2, 5'd0, 5'd2, 5'd2));
    emit(r_op(mips_pkg::F_JR, 5'd0, 5'd31, 5'd0, 5'd0));
    emit(i_op(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd3));
    run_program();
    // Link is call address plus 8
    check_equal("ram[0x80]", mem_inst.peek(32'h80), `MIPS_RESET_VECTOR + 32'd4 + 32'd8);
    check_equal("register_v0", register_v0, ((32'd7 + 32'd1) << 2) + 32'd3);
  endtask

  initial
  begin
    void'($urandom(32'h37b8));
    reset      = 1'b1;
    clk_enable = 1'b0;
    stall_mode = 1'b0;
    arith_logic_ops();
    stalled_rerun();
    load_store_sum();
    branch_slots();
    jal_jr_call();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
mips_pkg.sv
ctrl_if.sv
control_unit.sv
reg_file.sv
alu.sv
pc_unit.sv
mips_cpu_harvard.sv
tb_mem_model.sv
tb_mips_cpu_harvard.sv

/* Bender.yml */
package:
  name: mips_cpu_harvard

sources:
  - include_dirs:
      - .
    files:
      - mips_pkg.sv
      - ctrl_if.sv
      - control_unit.sv
      - reg_file.sv
      - alu.sv
      - pc_unit.sv
      - mips_cpu_harvard.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_model.sv
      - tb_mips_cpu_harvard.sv
